//--- build.f
verilog/router_pkg.sv
verilog/router_pkt_fifo.sv
verilog/router_ingress.sv
verilog/router_forward.sv
verilog/router_egress.sv
verilog/router_regs.sv
verilog/router_top.sv
test/router_tb.sv

//--- test/router_tb.sv
// Directed testbench for the packet router core
// Drives frames into the ingress ports and checks them at the egress ports and registers

`timescale 1ns/1ps

module router_tb
    import router_pkg::*;
();

    localparam int WAIT_CYCLES = 2000;
    localparam int REG_POLLS   = 200;
    localparam int MODEL_DEPTH = 512;

    logic                  clk;
    logic                  arst_n;
    logic [DATA_W-1:0]     ing_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0]  ing_tvalid;
    logic [NUM_PORTS-1:0]  ing_tlast;
    logic [NUM_PORTS-1:0]  ing_tready;
    logic [DATA_W-1:0]     egr_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0]  egr_tvalid;
    logic [NUM_PORTS-1:0]  egr_tlast;
    logic [NUM_PORTS-1:0]  egr_tready;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic                  reg_wr;
    logic                  reg_rd;
    logic [REG_W-1:0]      reg_wdata;
    logic [REG_W-1:0]      reg_rdata;
    logic                  reg_rvalid;

    logic [31:0]       lfsr;
    // Expected words per egress port, and words seen there ({last, data})
    logic [DATA_W-1:0] exp_mem [NUM_PORTS][MODEL_DEPTH];
    int                exp_wr  [NUM_PORTS];
    int                exp_rd  [NUM_PORTS];
    logic [DATA_W:0]   rx_mem  [NUM_PORTS][MODEL_DEPTH];
    int                rx_wr   [NUM_PORTS];
    int                rx_rd   [NUM_PORTS];
    // Table and counter model
    int                fwd_dest [NUM_PORTS];
    logic [REG_W-1:0]  exp_ing  [NUM_PORTS];
    logic [REG_W-1:0]  exp_egr  [NUM_PORTS];
    logic [REG_W-1:0]  exp_noroute;
    int                lens     [NUM_PORTS][3];

    router_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .ing_tdata  (ing_tdata),
        .ing_tvalid (ing_tvalid),
        .ing_tlast  (ing_tlast),
        .ing_tready (ing_tready),
        .egr_tdata  (egr_tdata),
        .egr_tvalid (egr_tvalid),
        .egr_tlast  (egr_tlast),
        .egr_tready (egr_tready),
        .reg_addr   (reg_addr),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Egress capture on the falling edge before each transfer
    always @(negedge clk) begin
        if (arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (egr_tvalid[p] && egr_tready[p]) begin
                    rx_mem[p][rx_wr[p]] = {egr_tlast[p], egr_tdata[p]};
                    rx_wr[p]++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp_val);
        if (got !== exp_val) begin
            abort_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp_val));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            abort_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp_val));
        end
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [REG_W-1:0] got,
                             input logic [REG_W-1:0] exp_val);
        if (got !== exp_val) begin
            abort_run($sformatf("error at %0t: %s got %h expected %h",
                                $time, addr.name(), got, exp_val));
        end
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [REG_W-1:0] data);
        @(posedge clk);
        reg_addr  <= addr;
        reg_wdata <= data;
        reg_wr    <= 1'b1;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [REG_W-1:0] data);
        int wait_cnt;
        @(posedge clk);
        reg_addr <= addr;
        reg_rd   <= 1'b1;
        @(posedge clk);
        reg_rd <= 1'b0;
        wait_cnt = 0;
        @(negedge clk);
        while (!reg_rvalid && wait_cnt < 10) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!reg_rvalid) begin
            abort_run("the register block gave no read response");
        end
        data = reg_rdata;
    endtask

    // Poll until the value settles, then compare
    task automatic wait_reg(input reg_addr_e addr, input logic [REG_W-1:0] exp_val);
        logic [REG_W-1:0] val;
        int tries;
        tries = 0;
        reg_read(addr, val);
        while (val !== exp_val && tries < REG_POLLS) begin
            reg_read(addr, val);
            tries++;
        end
        check_reg(addr, val, exp_val);
    endtask

    task automatic check_counters();
        logic [REG_W-1:0] val;
        for (int i = 0; i < NUM_PORTS; i++) begin
            reg_read(reg_addr_e'(REG_ING_DROP0 + i), val);
            check_reg(reg_addr_e'(REG_ING_DROP0 + i), val, exp_ing[i]);
            reg_read(reg_addr_e'(REG_EGR_DROP0 + i), val);
            check_reg(reg_addr_e'(REG_EGR_DROP0 + i), val, exp_egr[i]);
        end
        reg_read(REG_NOROUTE, val);
        check_reg(REG_NOROUTE, val, exp_noroute);
    endtask

    task automatic set_route(input int port, input int dest, input logic valid);
        reg_write(reg_addr_e'(REG_FWD0 + port), REG_W'({valid, PORT_W'(dest)}));
        fwd_dest[port] = dest;
    endtask

    // keep marks a frame the DUT is meant to deliver
    task automatic send_frame(input int port, input int len, input bit keep);
        logic [DATA_W-1:0] word;
        int dest;
        dest = fwd_dest[port];
        for (int i = 0; i < len; i++) begin
            word = rand_bits(DATA_W);
            @(posedge clk);
            ing_tvalid[port] <= 1'b1;
            ing_tlast[port]  <= (i == len - 1);
            ing_tdata[port]  <= word;
            if (keep) begin
                exp_mem[dest][exp_wr[dest]] = word;
                exp_wr[dest]++;
            end
        end
        @(posedge clk);
        ing_tvalid[port] <= 1'b0;
        ing_tlast[port]  <= 1'b0;
    endtask

    task automatic send_three(input int port);
        for (int f = 0; f < 3; f++) begin
            send_frame(port, lens[port][f], 1'b1);
        end
    endtask

    task automatic expect_frame(input int port, input int len);
        logic [DATA_W:0] got;
        int wait_cnt;
        for (int i = 0; i < len; i++) begin
            wait_cnt = 0;
            while (rx_rd[port] == rx_wr[port] && wait_cnt < WAIT_CYCLES) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (rx_rd[port] == rx_wr[port]) begin
                abort_run($sformatf("timeout waiting for word %0d on egress port %0d", i, port));
            end
            if (exp_rd[port] == exp_wr[port]) begin
                abort_run($sformatf("egress port %0d delivered a word nobody sent", port));
            end
            got = rx_mem[port][rx_rd[port]];
            rx_rd[port]++;
            check_word($sformatf("egr_tdata[%0d]", port), got[DATA_W-1:0],
                       exp_mem[port][exp_rd[port]]);
            check_bit($sformatf("egr_tlast[%0d]", port), got[DATA_W], i == len - 1);
            exp_rd[port]++;
        end
    endtask

    // Nothing may show up during a quiet window, and no word may be left over
    task automatic watch_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rx_rd[p] != rx_wr[p] || exp_rd[p] != exp_wr[p]) begin
                abort_run($sformatf("egress port %0d is out of step with the sent frames", p));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic reset_state();
        logic [REG_W-1:0] val;
        check_bit("reg_rvalid", reg_rvalid, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_bit($sformatf("egr_tvalid[%0d]", p), egr_tvalid[p], 1'b0);
            check_bit($sformatf("ing_tready[%0d]", p), ing_tready[p], 1'b1);
        end
        reg_read(REG_ID, val);
        check_reg(REG_ID, val, ROUTER_ID);
        reg_read(REG_CTRL, val);
        check_reg(REG_CTRL, val, '0);
        for (int i = 0; i < NUM_PORTS; i++) begin
            reg_read(reg_addr_e'(REG_FWD0 + i), val);
            check_reg(reg_addr_e'(REG_FWD0 + i), val, '0);
        end
        check_counters();
    endtask

    task automatic forward_all_ports();
        int len [NUM_PORTS];
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_route(p, (p + 2) % NUM_PORTS, 1'b1);
        end
        reg_write(REG_CTRL, 32'd1);
        // Both ends of the length range plus two drawn ones
        len[0] = 1;
        len[1] = 1 + int'(rand_bits(4));
        len[2] = 1 + int'(rand_bits(4));
        len[3] = MAX_FRAME_WORDS;
        for (int p = 0; p < NUM_PORTS; p++) begin
            send_frame(p, len[p], 1'b1);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            expect_frame(fwd_dest[p], len[p]);
        end
        watch_quiet(20);
    endtask

    task automatic drop_no_route();
        set_route(3, 1, 1'b0);
        send_frame(3, 8, 1'b0);
        exp_noroute = exp_noroute + 1;
        wait_reg(REG_NOROUTE, exp_noroute);
        watch_quiet(50);
        check_counters();
    endtask

    task automatic overflow_ingress();
        reg_write(REG_CTRL, 32'd0);
        for (int f = 0; f < 6; f++) begin
            send_frame(0, MAX_FRAME_WORDS, f < 4);
        end
        // A full buffer drops frames and still never stalls the port
        check_bit("ing_tready[0]", ing_tready[0], 1'b1);
        exp_ing[0] = exp_ing[0] + 2;
        check_counters();
        reg_write(REG_CTRL, 32'd1);
        for (int f = 0; f < 4; f++) begin
            expect_frame(fwd_dest[0], MAX_FRAME_WORDS);
        end
        watch_quiet(20);
    endtask

    task automatic stall_egress();
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_route(p, 1, 1'b1);
        end
        @(posedge clk);
        egr_tready[1] <= 1'b0;
        for (int f = 0; f < 6; f++) begin
            send_frame(f % NUM_PORTS, MAX_FRAME_WORDS, f < 4);
        end
        exp_egr[1] = exp_egr[1] + 2;
        wait_reg(REG_EGR_DROP1, exp_egr[1]);
        @(posedge clk);
        egr_tready[1] <= 1'b1;
        for (int f = 0; f < 4; f++) begin
            expect_frame(1, MAX_FRAME_WORDS);
        end
        watch_quiet(20);
        check_counters();
    endtask

    task automatic run_concurrent();
        for (int p = 0; p < NUM_PORTS; p++) begin
            set_route(p, (p + 2) % NUM_PORTS, 1'b1);
            for (int f = 0; f < 3; f++) begin
                lens[p][f] = 1 + int'(rand_bits(4));
            end
        end
        fork
            send_three(0);
            send_three(1);
            send_three(2);
            send_three(3);
        join
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int f = 0; f < 3; f++) begin
                expect_frame(fwd_dest[p], lens[p][f]);
            end
        end
        watch_quiet(20);
        check_counters();
    endtask

    initial begin
        lfsr        = 32'h6ba90f59;
        arst_n      = 1'b0;
        ing_tvalid  = '0;
        ing_tlast   = '0;
        egr_tready  = '1;
        reg_addr    = '0;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_wdata   = '0;
        exp_noroute = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ing_tdata[p] = '0;
            exp_wr[p]    = 0;
            exp_rd[p]    = 0;
            rx_wr[p]     = 0;
            rx_rd[p]     = 0;
            fwd_dest[p]  = 0;
            exp_ing[p]   = '0;
            exp_egr[p]   = '0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        reset_state();
        forward_all_ports();
        drop_no_route();
        overflow_ingress();
        stall_egress();
        run_concurrent();

        $display("All checks passed");
        $finish;
    end

endmodule

//--- verilog/router_egress.sv
// Egress side of the router: steers forwarded frames into one packet
// buffer per egress port, each buffer driving its own port

`timescale 1ns/1ps
`default_nettype none

module router_egress
    import router_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [DATA_W-1:0]    fwd_tdata,
    input  logic                 fwd_tvalid,
    input  logic                 fwd_tlast,
    input  logic [PORT_W-1:0]    fwd_tdest,
    output logic [DATA_W-1:0]    egr_tdata [NUM_PORTS],
    output logic [NUM_PORTS-1:0] egr_tvalid,
    output logic [NUM_PORTS-1:0] egr_tlast,
    input  logic [NUM_PORTS-1:0] egr_tready,
    output logic [NUM_PORTS-1:0] egr_drop
);

    // Write strobe per buffer; data and last fan out to all of them
    logic [NUM_PORTS-1:0] sel_tvalid;

    ////////////////////////////////////////////////////////////////////////////
    // Per-port demux and buffers

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // Destination is held over a frame by the forward stage
        assign sel_tvalid[i] = fwd_tvalid && (fwd_tdest == PORT_W'(i));

        router_pkt_fifo i_fifo (
            .clk        (clk),
            .arst_n     (arst_n),
            .in_tdata   (fwd_tdata),
            .in_tvalid  (sel_tvalid[i]),
            .in_tlast   (fwd_tlast),
            .out_tdata  (egr_tdata[i]),
            .out_tvalid (egr_tvalid[i]),
            .out_tlast  (egr_tlast[i]),
            .out_tready (egr_tready[i]),
            .drop       (egr_drop[i])
        );
    end

    // A frame never changes its buffer before its last word
    a_dest_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (fwd_tvalid && !fwd_tlast) |=> $stable(fwd_tdest));

endmodule

`default_nettype wire

//--- verilog/router_forward.sv
// Forwarding stage: looks up the egress port at start of frame and
// discards frames with no route; one register stage deep

`timescale 1ns/1ps
`default_nettype none

module router_forward
    import router_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   fwd_enable,
    input  logic [FWD_ENTRY_W-1:0] fwd_table [NUM_PORTS],
    input  logic [DATA_W-1:0]      bus_tdata,
    input  logic                   bus_tvalid,
    input  logic                   bus_tlast,
    input  logic [PORT_W-1:0]      bus_tport,
    output logic                   bus_tready,
    output logic [DATA_W-1:0]      fwd_tdata,
    output logic                   fwd_tvalid,
    output logic                   fwd_tlast,
    output logic [PORT_W-1:0]      fwd_tdest,
    output logic                   noroute_drop
);

    logic                   in_frame;
    logic                   route_ok;
    logic [PORT_W-1:0]      route_dest;
    logic                   bus_xfer;
    logic                   sof;
    logic                   cur_ok;
    logic [PORT_W-1:0]      cur_dest;
    logic [FWD_ENTRY_W-1:0] entry;

    // Disable only takes hold between frames, so no frame is cut
    assign bus_tready = fwd_enable || in_frame;
    assign bus_xfer   = bus_tvalid && bus_tready;
    assign sof        = bus_xfer && !in_frame;
    assign entry      = fwd_table[bus_tport];

    // First word uses the table, later words the latched copy
    assign cur_ok   = in_frame ? route_ok : entry[FWD_ENTRY_W-1];
    assign cur_dest = in_frame ? route_dest : entry[PORT_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_frame     <= 1'b0;
            route_ok     <= 1'b0;
            fwd_tvalid   <= 1'b0;
            noroute_drop <= 1'b0;
        end else begin
            if (bus_xfer) begin
                in_frame <= !bus_tlast;
            end
            if (sof) begin
                route_ok <= entry[FWD_ENTRY_W-1];
            end
            fwd_tvalid   <= bus_xfer && cur_ok;
            noroute_drop <= sof && !entry[FWD_ENTRY_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (sof) begin
            route_dest <= entry[PORT_W-1:0];
        end
        if (bus_xfer) begin
            fwd_tdata <= bus_tdata;
            fwd_tlast <= bus_tlast;
            fwd_tdest <= cur_dest;
        end
    end

endmodule

`default_nettype wire

//--- verilog/router_ingress.sv
// Ingress side of the router: one packet buffer per port and a
// round-robin frame arbiter that merges them onto the internal bus

`timescale 1ns/1ps
`default_nettype none

module router_ingress
    import router_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [DATA_W-1:0]    ing_tdata [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] ing_tvalid,
    input  logic [NUM_PORTS-1:0] ing_tlast,
    output logic [NUM_PORTS-1:0] ing_tready,
    output logic [DATA_W-1:0]    bus_tdata,
    output logic                 bus_tvalid,
    output logic                 bus_tlast,
    output logic [PORT_W-1:0]    bus_tport,
    input  logic                 bus_tready,
    output logic [NUM_PORTS-1:0] ing_drop
);

    logic [DATA_W-1:0]    buf_tdata [NUM_PORTS];
    logic [NUM_PORTS-1:0] buf_tvalid;
    logic [NUM_PORTS-1:0] buf_tlast;
    logic [NUM_PORTS-1:0] buf_tready;
    arb_state_e           state;
    logic [PORT_W-1:0]    grant;
    logic [PORT_W-1:0]    next_port;
    logic                 next_valid;
    logic                 bus_xfer;

    // Physical ports cannot stall; a full buffer drops instead
    assign ing_tready = '1;

    ////////////////////////////////////////////////////////////////////////////
    // Per-port packet buffers

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_buf
        router_pkt_fifo i_fifo (
            .clk        (clk),
            .arst_n     (arst_n),
            .in_tdata   (ing_tdata[i]),
            .in_tvalid  (ing_tvalid[i]),
            .in_tlast   (ing_tlast[i]),
            .out_tdata  (buf_tdata[i]),
            .out_tvalid (buf_tvalid[i]),
            .out_tlast  (buf_tlast[i]),
            .out_tready (buf_tready[i]),
            .drop       (ing_drop[i])
        );

        assign buf_tready[i] = (state == ARB_FRAME) && (grant == PORT_W'(i)) && bus_tready;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Round-robin arbiter

    // Search starts one past the last grant
    always_comb begin : rr_pick
        logic [PORT_W-1:0] cand;
        next_valid = 1'b0;
        next_port  = grant;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            cand = PORT_W'(grant + k);
            if (!next_valid && buf_tvalid[cand]) begin
                next_valid = 1'b1;
                next_port  = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
            // Port 0 wins first
            grant <= PORT_W'(NUM_PORTS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (next_valid) begin
                        grant <= next_port;
                        state <= ARB_FRAME;
                    end
                end
                ARB_FRAME: begin
                    if (bus_xfer && bus_tlast) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign bus_tvalid = (state == ARB_FRAME) && buf_tvalid[grant];
    assign bus_tdata  = buf_tdata[grant];
    assign bus_tlast  = buf_tlast[grant];
    assign bus_tport  = grant;
    assign bus_xfer   = bus_tvalid && bus_tready;

    a_grant_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (state == ARB_FRAME && !(bus_xfer && bus_tlast)) |=>
            (state == ARB_FRAME) && $stable(grant));

endmodule

`default_nettype wire

//--- verilog/router_pkg.sv
// Shared constants and types for the packet router core
// Imported by every router module and by the testbench

package router_pkg;

    // Port and datapath sizes
    localparam int NUM_PORTS   = 4;
    localparam int PORT_W      = 2;
    localparam int DATA_W      = 32;

    // Packet buffers
    localparam int FIFO_DEPTH      = 64;
    localparam int FIFO_AW         = 6;
    localparam int MAX_FRAME_WORDS = 16;

    // Forwarding entry is {valid, egress port}
    localparam int FWD_ENTRY_W = 3;

    // Register port
    localparam int REG_ADDR_W = 8;
    localparam int REG_W      = 32;

    localparam logic [REG_W-1:0] ROUTER_ID = 32'h5254_0100;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ID        = 8'h00,
        REG_CTRL      = 8'h01,
        REG_FWD0      = 8'h04,
        REG_FWD1      = 8'h05,
        REG_FWD2      = 8'h06,
        REG_FWD3      = 8'h07,
        REG_ING_DROP0 = 8'h08,
        REG_ING_DROP1 = 8'h09,
        REG_ING_DROP2 = 8'h0A,
        REG_ING_DROP3 = 8'h0B,
        REG_EGR_DROP0 = 8'h0C,
        REG_EGR_DROP1 = 8'h0D,
        REG_EGR_DROP2 = 8'h0E,
        REG_EGR_DROP3 = 8'h0F,
        REG_NOROUTE   = 8'h10
    } reg_addr_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_FRAME
    } arb_state_e;

endpackage

//--- verilog/router_pkt_fifo.sv
// Packet buffer that keeps or drops whole frames and streams them out
// Used once per port on both the ingress and the egress side

`timescale 1ns/1ps
`default_nettype none

module router_pkt_fifo
    import router_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic [DATA_W-1:0] in_tdata,
    input  logic              in_tvalid,
    input  logic              in_tlast,
    output logic [DATA_W-1:0] out_tdata,
    output logic              out_tvalid,
    output logic              out_tlast,
    input  logic              out_tready,
    output logic              drop
);

    // Word plus last flag in the top bit
    logic [DATA_W:0]    mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic [FIFO_AW:0]   free;
    logic               in_frame;
    logic               discard;
    logic               sof;
    logic               admit;
    logic               wr_en;
    logic               rd_en;

    // Admission is decided once, on the first word of a frame
    assign free  = (FIFO_AW + 1)'(FIFO_DEPTH) - count;
    assign sof   = in_tvalid && !in_frame;
    assign admit = free >= (FIFO_AW + 1)'(MAX_FRAME_WORDS);
    assign wr_en = in_tvalid && (sof ? admit : !discard);
    assign drop  = sof && !admit;
    assign rd_en = out_tvalid && out_tready;

    assign out_tvalid              = (count != '0);
    assign {out_tlast, out_tdata}  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {in_tlast, in_tdata};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_frame <= 1'b0;
            discard  <= 1'b0;
        end else begin
            if (in_tvalid) begin
                in_frame <= !in_tlast;
            end
            // Remember the verdict until the frame's last word
            if (sof) begin
                discard <= !admit;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
        count <= (FIFO_AW + 1)'(FIFO_DEPTH));

    // Output only comes up after a word has really been stored
    a_valid_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_tvalid) |-> $past(wr_en) && $past(count) == '0);

endmodule

`default_nettype wire

//--- verilog/router_regs.sv
// Software register block: module ID, forwarding enable, table entries
// and the frame drop counters

`timescale 1ns/1ps
`default_nettype none

module router_regs
    import router_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [REG_ADDR_W-1:0]  reg_addr,
    input  logic                   reg_wr,
    input  logic                   reg_rd,
    input  logic [REG_W-1:0]       reg_wdata,
    output logic [REG_W-1:0]       reg_rdata,
    output logic                   reg_rvalid,
    output logic                   fwd_enable,
    output logic [FWD_ENTRY_W-1:0] fwd_table [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]   ing_drop,
    input  logic [NUM_PORTS-1:0]   egr_drop,
    input  logic                   noroute_drop
);

    logic [REG_W-1:0]  ing_cnt [NUM_PORTS];
    logic [REG_W-1:0]  egr_cnt [NUM_PORTS];
    logic [REG_W-1:0]  noroute_cnt;
    logic [REG_W-1:0]  rd_mux;
    logic [PORT_W-1:0] idx;
    reg_addr_e         addr;

    assign addr = reg_addr_e'(reg_addr);
    // Banked registers sit four-aligned, low bits pick the port
    assign idx  = reg_addr[PORT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Control and forwarding table

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_enable <= 1'b0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                fwd_table[i] <= '0;
            end
        end else if (reg_wr) begin
            case (addr)
                REG_CTRL: fwd_enable <= reg_wdata[0];
                REG_FWD0, REG_FWD1, REG_FWD2, REG_FWD3: begin
                    fwd_table[idx] <= reg_wdata[FWD_ENTRY_W-1:0];
                end
                default: ;
            endcase
        end
    end

    // Drop counters, free running and wrapping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                ing_cnt[i] <= '0;
                egr_cnt[i] <= '0;
            end
            noroute_cnt <= '0;
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (ing_drop[i]) begin
                    ing_cnt[i] <= ing_cnt[i] + 1'b1;
                end
                if (egr_drop[i]) begin
                    egr_cnt[i] <= egr_cnt[i] + 1'b1;
                end
            end
            if (noroute_drop) begin
                noroute_cnt <= noroute_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read path

    always_comb begin
        case (addr)
            REG_ID:   rd_mux = ROUTER_ID;
            REG_CTRL: rd_mux = REG_W'(fwd_enable);
            REG_FWD0, REG_FWD1, REG_FWD2, REG_FWD3: rd_mux = REG_W'(fwd_table[idx]);
            REG_ING_DROP0, REG_ING_DROP1, REG_ING_DROP2, REG_ING_DROP3: rd_mux = ing_cnt[idx];
            REG_EGR_DROP0, REG_EGR_DROP1, REG_EGR_DROP2, REG_EGR_DROP3: rd_mux = egr_cnt[idx];
            REG_NOROUTE: rd_mux = noroute_cnt;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n)
        !(reg_wr && reg_rd));

endmodule

`default_nettype wire

//--- verilog/router_top.sv
// Top level of the packet router core
// Ingress buffers feed the forwarding stage, which feeds the egress buffers

`timescale 1ns/1ps
`default_nettype none

module router_top
    import router_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [DATA_W-1:0]     ing_tdata [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]  ing_tvalid,
    input  logic [NUM_PORTS-1:0]  ing_tlast,
    output logic [NUM_PORTS-1:0]  ing_tready,
    output logic [DATA_W-1:0]     egr_tdata [NUM_PORTS],
    output logic [NUM_PORTS-1:0]  egr_tvalid,
    output logic [NUM_PORTS-1:0]  egr_tlast,
    input  logic [NUM_PORTS-1:0]  egr_tready,
    input  logic [REG_ADDR_W-1:0] reg_addr,
    input  logic                  reg_wr,
    input  logic                  reg_rd,
    input  logic [REG_W-1:0]      reg_wdata,
    output logic [REG_W-1:0]      reg_rdata,
    output logic                  reg_rvalid
);

    // Internal bus, ingress to forward
    logic [DATA_W-1:0]      bus_tdata;
    logic                   bus_tvalid;
    logic                   bus_tlast;
    logic [PORT_W-1:0]      bus_tport;
    logic                   bus_tready;

    // Forward to egress, no back-pressure
    logic [DATA_W-1:0]      fwd_tdata;
    logic                   fwd_tvalid;
    logic                   fwd_tlast;
    logic [PORT_W-1:0]      fwd_tdest;

    // Control and drop reporting
    logic                   fwd_enable;
    logic [FWD_ENTRY_W-1:0] fwd_table [NUM_PORTS];
    logic [NUM_PORTS-1:0]   ing_drop;
    logic [NUM_PORTS-1:0]   egr_drop;
    logic                   noroute_drop;

    router_ingress i_ingress (.*);

    router_forward i_forward (.*);

    router_egress i_egress (.*);

    router_regs i_regs (.*);

endmodule

`default_nettype wire
